// File: common/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  // ==========================================================================
  // Bus geometry
  // ==========================================================================
  localparam int ahb_addr_width = 32;
  localparam int ahb_data_width = 32;
  localparam int num_masters    = 2;
  // Mapped slaves only, default slave comes on top
  localparam int num_slaves     = 2;
  localparam int regfile_words  = 16;

  // Index widths derived from the counts above
  localparam int master_idx_width   = $clog2(num_masters);
  localparam int regfile_addr_width = $clog2(regfile_words);

  // ==========================================================================
  // Address map, inclusive bounds
  // ==========================================================================
  // Highest slave first in the concatenation
  localparam logic [num_slaves-1:0][ahb_addr_width-1:0] slave_base =
    {32'h0000_1000, 32'h0000_0000};
  localparam logic [num_slaves-1:0][ahb_addr_width-1:0] slave_limit =
    {32'h0000_103F, 32'h0000_003F};

  // Transfer type as carried on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // No SPLIT or RETRY, so one bit is enough
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Master request, hwdata rides one phase behind the rest
  typedef struct packed {
    logic [ahb_addr_width-1:0] haddr;
    htrans_e                   htrans;
    logic                      hwrite;
    logic [2:0]                hsize;
    logic [ahb_data_width-1:0] hwdata;
    // Alignment bit, always zero
    logic                      rsvd;
  } ahb_req_t;

  // Slave response
  typedef struct packed {
    logic [ahb_data_width-1:0] hrdata;
    logic                      hready;
    hresp_e                    hresp;
  } ahb_resp_t;

endpackage

`default_nettype wire

// File: ahb_decoder/ahb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_decoder import ahb_pkg::*; (
  input  logic [ahb_addr_width-1:0] haddr,
  input  htrans_e                   htrans,
  output logic [num_slaves-1:0]     hsel,
  output logic                      default_sel
);

  // ==========================================================================
  // Address match per slave
  // ==========================================================================
  logic [num_slaves-1:0] slave_hit;
  // Only real transfers select anything
  logic                  xfer_active;

  always_comb begin
    for (int i = 0; i < num_slaves; i++) begin
      // Both bounds inclusive
      slave_hit[i] = (haddr >= slave_base[i]) && (haddr <= slave_limit[i]);
    end
  end

  // IDLE and BUSY excluded here
  assign xfer_active = (htrans == NONSEQ) || (htrans == SEQ);

  // ==========================================================================
  // Select outputs
  // ==========================================================================
  // Address map has no overlaps, so at most one bit
  assign hsel = xfer_active ? slave_hit : '0;

  // Hole in the map goes to the default slave
  assign default_sel = xfer_active && (slave_hit == '0);

endmodule

`default_nettype wire

// File: ahb_arbiter/ahb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_arbiter import ahb_pkg::*; (
  input  logic                   hclk,
  input  logic                   rst,
  input  ahb_req_t               master_req [num_masters],
  input  logic [num_masters-1:0] busreq,
  input  logic                   hready_in,
  output logic [num_masters-1:0] hgrant,
  output ahb_req_t               bus_req
);

  // ==========================================================================
  // Ownership state
  // ==========================================================================
  // Round-robin pointer, index of the address-phase owner
  logic [master_idx_width-1:0] addr_owner;
  // Owner of the transfer now in its data phase
  logic [master_idx_width-1:0] data_owner;
  logic [master_idx_width-1:0] next_owner;
  logic [master_idx_width-1:0] cand;

  // Next owner search
  always_comb begin
    next_owner = addr_owner;
    cand       = addr_owner;
    if (!busreq[addr_owner]) begin
      // Nobody asking, park on master 0
      next_owner = '0;
      // Walk backwards so the nearest requester wins
      for (int k = num_masters - 1; k >= 1; k--) begin
        cand = master_idx_width'((int'(addr_owner) + k) % num_masters);
        if (busreq[cand]) begin
          next_owner = cand;
        end
      end
    end
  end

  // Grant only moves on hready high
  always_ff @(posedge hclk) begin
    if (rst) begin
      addr_owner <= '0;
      data_owner <= '0;
      hgrant     <= num_masters'(1);
    end else if (hready_in) begin
      addr_owner <= next_owner;
      // Accepted address phase becomes the data phase
      data_owner <= addr_owner;
      hgrant     <= num_masters'(1) << next_owner;
    end
  end

  // ==========================================================================
  // Master multiplexing
  // ==========================================================================
  always_comb begin
    bus_req        = master_req[addr_owner];
    // Write data lags by one phase
    bus_req.hwdata = master_req[data_owner].hwdata;
    bus_req.rsvd   = 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/ahb_default_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_default_slave import ahb_pkg::*; (
  input  logic      hclk,
  input  logic      rst,
  input  logic      default_sel,
  input  logic      hready_in,
  output ahb_resp_t resp
);

  // ==========================================================================
  // Two-cycle ERROR FSM
  // ==========================================================================
  typedef enum logic [1:0] {
    S_IDLE,
    // First ERROR cycle, hready low
    S_ERR_LOW,
    // Second ERROR cycle, hready high
    S_ERR_HIGH
  } state_e;

  state_e state;

  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_ERR_LOW: state <= S_ERR_HIGH;
        // Back-to-back unmapped accesses restart the sequence
        default:   state <= (default_sel && hready_in) ? S_ERR_LOW : S_IDLE;
      endcase
    end
  end

  // Outputs straight from the state register
  assign resp.hrdata = '0;
  assign resp.hready = (state != S_ERR_LOW);
  assign resp.hresp  = (state == S_IDLE) ? OKAY : ERROR;

endmodule

`default_nettype wire

// File: verilog/ahb_regfile_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_regfile_slave import ahb_pkg::*; (
  input  logic      hclk,
  input  logic      rst,
  input  logic      hsel,
  input  ahb_req_t  bus_req,
  input  logic      hready_in,
  output ahb_resp_t resp
);

  // ==========================================================================
  // Storage and data-phase state
  // ==========================================================================
  logic [ahb_data_width-1:0]     mem [regfile_words];
  logic [regfile_addr_width-1:0] dp_idx;
  logic [ahb_data_width-1:0]     hrdata_q;
  logic                          accept;
  // Write data phase pending
  logic                          wr_pend;
  // Read wait state, drives hready low
  logic                          rd_wait;

  // Address phase taken only when the bus is ready
  assign accept = hsel && hready_in;

  always_ff @(posedge hclk) begin
    if (rst) begin
      wr_pend <= 1'b0;
      rd_wait <= 1'b0;
    end else begin
      wr_pend <= accept && bus_req.hwrite;
      rd_wait <= accept && !bus_req.hwrite;
    end
  end

  // Word index from haddr[5:2]
  always_ff @(posedge hclk) begin
    if (accept) begin
      dp_idx <= bus_req.haddr[2 +: regfile_addr_width];
    end
    // Read data lands for the second data cycle
    if (rd_wait) begin
      hrdata_q <= mem[dp_idx];
    end
  end

  // Register file, cleared on reset
  always_ff @(posedge hclk) begin
    if (rst) begin
      for (int i = 0; i < regfile_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_pend && hready_in) begin
      mem[dp_idx] <= bus_req.hwdata;
    end
  end

  assign resp.hrdata = hrdata_q;
  assign resp.hready = !rd_wait;
  assign resp.hresp  = OKAY;

endmodule

`default_nettype wire

// File: verilog/ahb_slave_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_mux import ahb_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst,
  input  logic [num_slaves-1:0] hsel,
  input  logic                  default_sel,
  input  logic                  hready_in,
  input  ahb_resp_t             slave_resp [num_slaves],
  input  ahb_resp_t             default_resp,
  output ahb_resp_t             bus_resp
);

  // ==========================================================================
  // Data-phase owner
  // ==========================================================================
  logic [num_slaves-1:0] dp_hsel;
  logic                  dp_default;

  // Follows the address phase that was just accepted
  always_ff @(posedge hclk) begin
    if (rst) begin
      dp_hsel    <= '0;
      dp_default <= 1'b0;
    end else if (hready_in) begin
      dp_hsel    <= hsel;
      dp_default <= default_sel;
    end
  end

  // ==========================================================================
  // Response select
  // ==========================================================================
  always_comb begin
    // No owner, zero-wait OKAY
    bus_resp.hrdata = '0;
    bus_resp.hready = 1'b1;
    bus_resp.hresp  = OKAY;
    for (int i = 0; i < num_slaves; i++) begin
      if (dp_hsel[i]) begin
        bus_resp = slave_resp[i];
      end
    end
    if (dp_default) begin
      bus_resp = default_resp;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ahb_bus.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_bus import ahb_pkg::*; (
  input  logic                   hclk,
  input  logic                   rst,
  input  ahb_req_t               master_req [num_masters],
  input  logic [num_masters-1:0] busreq,
  output logic [num_masters-1:0] hgrant,
  output ahb_resp_t              bus_resp
);

  // ==========================================================================
  // Internal bus
  // ==========================================================================
  ahb_req_t              bus_req;
  logic [num_slaves-1:0] hsel;
  logic                  default_sel;
  ahb_resp_t             slave_resp [num_slaves];
  ahb_resp_t             default_resp;

  // Master side
  ahb_arbiter i_arbiter (
    .hclk       (hclk),
    .rst        (rst),
    .master_req (master_req),
    .busreq     (busreq),
    .hready_in  (bus_resp.hready),
    .hgrant     (hgrant),
    .bus_req    (bus_req)
  );

  // Address-phase decode
  ahb_decoder i_decoder (
    .haddr       (bus_req.haddr),
    .htrans      (bus_req.htrans),
    .hsel        (hsel),
    .default_sel (default_sel)
  );

  // ==========================================================================
  // Slaves
  // ==========================================================================
  ahb_regfile_slave i_slave0 (
    .hclk      (hclk),
    .rst       (rst),
    .hsel      (hsel[0]),
    .bus_req   (bus_req),
    .hready_in (bus_resp.hready),
    .resp      (slave_resp[0])
  );

  ahb_regfile_slave i_slave1 (
    .hclk      (hclk),
    .rst       (rst),
    .hsel      (hsel[1]),
    .bus_req   (bus_req),
    .hready_in (bus_resp.hready),
    .resp      (slave_resp[1])
  );

  // Catches the holes in the map
  ahb_default_slave i_default_slave (
    .hclk        (hclk),
    .rst         (rst),
    .default_sel (default_sel),
    .hready_in   (bus_resp.hready),
    .resp        (default_resp)
  );

  // Response back to all masters
  ahb_slave_mux i_slave_mux (
    .hclk         (hclk),
    .rst          (rst),
    .hsel         (hsel),
    .default_sel  (default_sel),
    .hready_in    (bus_resp.hready),
    .slave_resp   (slave_resp),
    .default_resp (default_resp),
    .bus_resp     (bus_resp)
  );

endmodule

`default_nettype wire

// File: sim/ahb_bus_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_bus_assertions import ahb_pkg::*; (
  input logic                   hclk,
  input logic                   rst,
  input logic [num_masters-1:0] hgrant,
  input ahb_req_t               bus_req,
  input ahb_resp_t              bus_resp,
  input logic [num_slaves-1:0]  hsel,
  input logic                   default_sel
);

  // ==========================================================================
  // Bus protocol properties
  // ==========================================================================
  // Exactly one owner at all times
  grant_onehot: assert property (@(posedge hclk) disable iff (rst)
    $onehot(hgrant))
    else $error("hgrant not one-hot");

  // Address phase held through wait states
  addr_stable: assert property (@(posedge hclk) disable iff (rst)
    !bus_resp.hready |=> $stable(bus_req.haddr) && $stable(bus_req.htrans) &&
                         $stable(bus_req.hwrite) && $stable(bus_req.hsize))
    else $error("address phase changed while hready low");

  // Two-cycle ERROR
  error_two_cycle: assert property (@(posedge hclk) disable iff (rst)
    (bus_resp.hresp == ERROR && !bus_resp.hready) |=>
      (bus_resp.hresp == ERROR && bus_resp.hready))
    else $error("ERROR response not completed in second cycle");

  // Decoder never selects two responders
  sel_exclusive: assert property (@(posedge hclk) disable iff (rst)
    !((|hsel) && default_sel))
    else $error("hsel and default_sel both high");

endmodule

`default_nettype wire

// File: sim/ahb_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_bus_tb import ahb_pkg::*; ();

  // ==========================================================================
  // DUT, clock and shared state
  // ==========================================================================
  logic                   hclk;
  logic                   rst;
  ahb_req_t               master_req [num_masters];
  logic [num_masters-1:0] busreq;
  logic [num_masters-1:0] hgrant;
  ahb_resp_t              bus_resp;

  // Expected register contents, one row per slave
  logic [ahb_data_width-1:0] model [num_slaves][regfile_words];
  logic [31:0]               lfsr_state;
  // hgrant as seen at each accepted address phase
  logic [num_masters-1:0]    grant_log [$];
  int                        errors;
  int                        checks;
  int                        wait_limit = 64;

  ahb_bus i_dut (
    .hclk       (hclk),
    .rst        (rst),
    .master_req (master_req),
    .busreq     (busreq),
    .hgrant     (hgrant),
    .bus_resp   (bus_resp)
  );

  // Protocol checks on the top level internals
  bind ahb_bus ahb_bus_assertions i_assertions (
    .hclk        (hclk),
    .rst         (rst),
    .hgrant      (hgrant),
    .bus_req     (bus_req),
    .bus_resp    (bus_resp),
    .hsel        (hsel),
    .default_sel (default_sel)
  );

  // 4 ns period
  initial hclk = 1'b0;
  always #2 hclk = ~hclk;

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic check_data(input string name, input logic [ahb_data_width-1:0] got,
                            input logic [ahb_data_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input hresp_e got, input hresp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_grant(input string name, input logic [num_masters-1:0] got,
                             input logic [num_masters-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
    $display("Test failures found");
    $finish;
  endtask

  task automatic report_test(input string name, input int start);
    $display("Test %s: %s", name, (errors == start) ? "ok" : "FAILED");
  endtask

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [ahb_addr_width-1:0] word_addr(input int s, input int w);
    return slave_base[s] + (w << 2);
  endfunction

  // Single transfer, called and returning on a falling edge
  task automatic bus_xfer(
    input  int                        m,
    input  logic [ahb_addr_width-1:0] addr,
    input  htrans_e                   trans,
    input  logic                      write,
    input  logic [ahb_data_width-1:0] wdata,
    output logic [ahb_data_width-1:0] rdata,
    output hresp_e                    first_resp,
    output hresp_e                    last_resp,
    output int                        waits
  );
    int cnt;
    busreq[m] = 1'b1;
    cnt = 0;
    while (!hgrant[m]) begin
      @(negedge hclk);
      cnt++;
      if (cnt > wait_limit) begin
        abort_on_timeout("hgrant");
      end
    end
    // Address phase
    master_req[m].haddr  = addr;
    master_req[m].htrans = trans;
    master_req[m].hwrite = write;
    master_req[m].hsize  = 3'b010;
    cnt = 0;
    while (!bus_resp.hready) begin
      @(negedge hclk);
      cnt++;
      if (cnt > wait_limit) begin
        abort_on_timeout("hready for the address phase");
      end
    end
    grant_log.push_back(hgrant);
    @(negedge hclk);
    // Data phase, next address phase idles
    master_req[m].hwdata = wdata;
    master_req[m].htrans = IDLE;
    busreq[m]            = 1'b0;
    first_resp           = bus_resp.hresp;
    waits                = 0;
    while (!bus_resp.hready) begin
      @(negedge hclk);
      waits++;
      if (waits > wait_limit) begin
        abort_on_timeout("end of the data phase");
      end
    end
    rdata     = bus_resp.hrdata;
    last_resp = bus_resp.hresp;
    @(negedge hclk);
  endtask

  // Holds busreq until the grant sits on master m
  task automatic claim_grant(input int m);
    int cnt;
    busreq[m] = 1'b1;
    cnt = 0;
    while (!hgrant[m]) begin
      @(negedge hclk);
      cnt++;
      if (cnt > wait_limit) begin
        abort_on_timeout("hgrant");
      end
    end
  endtask

  task automatic write_word(input int m, input int s, input int w,
                            input logic [ahb_data_width-1:0] data);
    logic [ahb_data_width-1:0] rdata;
    hresp_e                    first_resp;
    hresp_e                    last_resp;
    int                        waits;
    bus_xfer(m, word_addr(s, w), NONSEQ, 1'b1, data, rdata, first_resp, last_resp, waits);
    check_resp("bus_resp.hresp", last_resp, OKAY);
    check_count("write wait states", waits, 0);
    model[s][w] = data;
  endtask

  task automatic read_word(input int m, input int s, input int w);
    logic [ahb_data_width-1:0] rdata;
    hresp_e                    first_resp;
    hresp_e                    last_resp;
    int                        waits;
    bus_xfer(m, word_addr(s, w), NONSEQ, 1'b0, '0, rdata, first_resp, last_resp, waits);
    check_data("bus_resp.hrdata", rdata, model[s][w]);
    check_resp("bus_resp.hresp first cycle", first_resp, OKAY);
    check_resp("bus_resp.hresp", last_resp, OKAY);
    // Exactly one hready-low cycle per read
    check_count("read wait states", waits, 1);
  endtask

  task automatic verify_all();
    for (int s = 0; s < num_slaves; s++) begin
      for (int w = 0; w < regfile_words; w++) begin
        read_word(0, s, w);
      end
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (5) @(negedge hclk);
    rst    = 1'b0;
    // Requests held through reset drop as it releases
    busreq = '0;
    for (int s = 0; s < num_slaves; s++) begin
      for (int w = 0; w < regfile_words; w++) begin
        model[s][w] = '0;
      end
    end
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_reset_state(input string name);
    int start;
    start = errors;
    apply_reset();
    check_grant("hgrant", hgrant, 2'b01);
    check_flag("bus_resp.hready", bus_resp.hready, 1'b1);
    check_resp("bus_resp.hresp", bus_resp.hresp, OKAY);
    // Model is all zero now
    verify_all();
    report_test(name, start);
  endtask

  task automatic test_write_read();
    int          start;
    int          words [3] = '{0, 7, 15};
    logic [31:0] d;
    start = errors;
    for (int s = 0; s < num_slaves; s++) begin
      for (int i = 0; i < 3; i++) begin
        take_bits(32, d);
        write_word(0, s, words[i], d);
      end
    end
    for (int s = 0; s < num_slaves; s++) begin
      for (int i = 0; i < 3; i++) begin
        read_word(0, s, words[i]);
      end
    end
    report_test("write and read back", start);
  endtask

  task automatic test_unmapped();
    int                        start;
    logic [ahb_data_width-1:0] rdata;
    hresp_e                    first_resp;
    hresp_e                    last_resp;
    int                        waits;
    start = errors;
    // Write then read to the hole at 0x800
    for (int wr = 1; wr >= 0; wr--) begin
      bus_xfer(0, 32'h0000_0800, NONSEQ, wr[0], 32'hdead_beef, rdata, first_resp,
               last_resp, waits);
      check_resp("bus_resp.hresp first cycle", first_resp, ERROR);
      check_resp("bus_resp.hresp last cycle", last_resp, ERROR);
      check_count("error wait states", waits, 1);
      check_data("bus_resp.hrdata", rdata, '0);
    end
    verify_all();
    report_test("unmapped access", start);
  endtask

  task automatic test_idle_busy();
    int                        start;
    logic [ahb_addr_width-1:0] addrs [3];
    logic [ahb_data_width-1:0] rdata;
    hresp_e                    first_resp;
    hresp_e                    last_resp;
    int                        waits;
    start    = errors;
    addrs[0] = word_addr(0, 3);
    addrs[1] = word_addr(1, 9);
    addrs[2] = 32'h0000_0800;
    for (int i = 0; i < 3; i++) begin
      for (int t = 0; t < 2; t++) begin
        bus_xfer(0, addrs[i], (t == 0) ? IDLE : BUSY, 1'b1, 32'hffff_0000 | i, rdata,
                 first_resp, last_resp, waits);
        check_resp("bus_resp.hresp first cycle", first_resp, OKAY);
        check_resp("bus_resp.hresp last cycle", last_resp, OKAY);
        check_count("idle wait states", waits, 0);
      end
    end
    verify_all();
    report_test("idle and busy", start);
  endtask

  task automatic test_arbitration();
    int                     start;
    logic [31:0]            d [4];
    logic [num_masters-1:0] exp_order [4] = '{2'b01, 2'b10, 2'b01, 2'b10};
    start = errors;
    for (int i = 0; i < 4; i++) begin
      take_bits(32, d[i]);
    end
    grant_log.delete();
    // Both masters ask at once, one transfer per tenure
    fork
      begin
        write_word(0, 0, 8, d[0]);
        write_word(0, 0, 9, d[1]);
      end
      begin
        write_word(1, 1, 8, d[2]);
        write_word(1, 1, 9, d[3]);
      end
    join
    check_count("grant log length", grant_log.size(), 4);
    if (grant_log.size() == 4) begin
      for (int i = 0; i < 4; i++) begin
        check_grant("hgrant at address phase", grant_log[i], exp_order[i]);
      end
    end
    // Parks on master 0 with no requests
    check_grant("hgrant", hgrant, 2'b01);
    read_word(0, 0, 8);
    read_word(0, 0, 9);
    read_word(1, 1, 8);
    read_word(1, 1, 9);
    report_test("arbitration", start);
  endtask

  task automatic test_random();
    int          start;
    logic [31:0] v;
    logic [31:0] d;
    int          m;
    int          s;
    int          w;
    start = errors;
    for (int i = 0; i < 40; i++) begin
      take_bits(1, v);
      m = int'(v);
      take_bits(1, v);
      s = int'(v);
      take_bits(4, v);
      w = int'(v);
      take_bits(1, v);
      if (v[0]) begin
        take_bits(32, d);
        write_word(m, s, w, d);
      end else begin
        read_word(m, s, w);
      end
    end
    report_test("random traffic", start);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    rst        = 1'b1;
    busreq     = '0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'h5b75;
    for (int m = 0; m < num_masters; m++) begin
      master_req[m] = '0;
    end
    test_reset_state("reset state");
    test_write_read();
    test_unmapped();
    test_idle_busy();
    test_arbitration();
    test_random();
    // Memory is dirty and master 1 owns the bus going into reset
    claim_grant(1);
    test_reset_state("mid-test reset");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ahb_bus.f
common/ahb_pkg.sv
ahb_decoder/ahb_decoder.sv
ahb_arbiter/ahb_arbiter.sv
verilog/ahb_default_slave.sv
verilog/ahb_regfile_slave.sv
verilog/ahb_slave_mux.sv
verilog/ahb_bus.sv
sim/ahb_bus_assertions.sv
sim/ahb_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB bus testbench with Verilator
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module ahb_bus_tb -f ahb_bus.f --Mdir obj_dir -o ahb_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ahb_bus_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$log"; then
  exit 1
fi
exit 0
